// File: rtl/alu_op_classifier.sv
//////////////////////////////
// ALU opcode classifier
// Maps an opcode onto one of nine wear classes
//////////////////////////////
module alu_op_classifier import alu_wear_pkg::*; (
  input  alu_op_e   op_i,
  output op_class_e class_o
);

  always_comb begin
    case (op_i)
      // Add and shift
      OP_ADD,
      OP_SRL:   class_o = CLS_ADD_SHIFT;
      // Bitwise logic
      OP_XOR,
      OP_AND:   class_o = CLS_LOGIC;
      // Single bit set and clear
      OP_BCLR,
      OP_BSET:  class_o = CLS_BIT_MAN;
      // Find first one, popcount
      OP_FF1,
      OP_CNT:   class_o = CLS_BIT_CNT;
      // Byte and half shuffles
      OP_SHUF,
      OP_PCKLO: class_o = CLS_SHUFFLE;
      // Compares
      OP_LTS,
      OP_EQ:    class_o = CLS_COMPARE;
      // Absolute and clip
      OP_ABS,
      OP_CLIP:  class_o = CLS_ABS_CLIP;
      // Min and max
      OP_MIN,
      OP_MAXU:  class_o = CLS_MIN_MAX;
      // Divider
      OP_DIV,
      OP_REMU:  class_o = CLS_DIV_REM;
      // Anything else is unknown
      default:  class_o = CLS_NONE;
    endcase
  end

endmodule

// File: rtl/alu_wear_lane.sv
//////////////////////////////
// ALU wear lane
// Nine leaky error counters with sticky fault flags for one ALU
// Fires a one cycle event when a class goes faulty
//////////////////////////////
module alu_wear_lane import alu_wear_pkg::*; #(
  parameter int LANE = 0
) (
  input  logic            clock_gated,
  input  logic            rst_n,
  input  logic            valid_i,
  input  alu_op_e         op_i,
  input  logic            error_i,
  wear_cfg_if.lane        cfg,
  output logic            event_o
);

  op_class_e                       op_class;
  logic                            active;
  logic                            clear_lane;
  logic [NUM_CLASS-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_CLASS-1:0][CNT_W-1:0] cnt_d;
  class_flags_t                    flags_q;
  class_flags_t                    flags_set;

  alu_op_classifier i_classifier (
    .op_i    (op_i),
    .class_o (op_class)
  );

  // Only enabled lanes see their traffic
  assign active     = cfg.lane_en[LANE] & valid_i;
  assign clear_lane = cfg.lane_clear[LANE];

  //////////////////////////////
  // Next counter state
  //////////////////////////////
  always_comb begin
    logic [CNT_W-1:0] cnt_inc;
    cnt_d     = cnt_q;
    flags_set = '0;
    for (int k = 0; k < NUM_CLASS; k++) begin
      // Saturate at all ones
      cnt_inc = (cnt_q[k] == '1) ? cnt_q[k] : cnt_q[k] + 1'b1;
      if (flags_q[k]) begin
        // Faulty class stays parked at zero
        cnt_d[k] = '0;
      end else if (active && (op_class == op_class_e'(k))) begin
        if (error_i) begin
          if (cnt_inc >= cfg.threshold) begin
            // Threshold hit, mark class and restart count
            flags_set[k] = 1'b1;
            cnt_d[k]     = '0;
          end else begin
            cnt_d[k] = cnt_inc;
          end
        end else begin
          // Clean op leaks, floor at zero
          cnt_d[k] = (cnt_q[k] > cfg.leak) ? cnt_q[k] - cfg.leak : '0;
        end
      end
    end
    // Unknown op wipes progress but keeps the flags
    if (active && (op_class == CLS_NONE)) begin
      cnt_d = '0;
    end
  end

  //////////////////////////////
  // State registers
  //////////////////////////////
  always_ff @(posedge clock_gated) begin
    if (!rst_n || clear_lane) begin
      cnt_q   <= '0;
      flags_q <= '0;
      event_o <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      // Flags are sticky until a clear
      flags_q <= flags_q | flags_set;
      // Pulse for the perf counter
      event_o <= |flags_set;
    end
  end

  // Own slice of the shared flag vector
  assign cfg.fault_flags[LANE] = flags_q;

endmodule

// File: rtl/alu_wear_monitor.sv
//////////////////////////////
// ALU wear monitor top
// APB register block plus one wear lane per ALU
//////////////////////////////
module alu_wear_monitor import alu_wear_pkg::*; #(
  parameter int NUM_ALU = alu_wear_pkg::NUM_ALU
) (
  input  logic                       clock_gated,
  input  logic                       rst_n,
  // APB slave
  input  logic [APB_AW-1:0]          paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [APB_DW-1:0]          pwdata_i,
  output logic [APB_DW-1:0]          prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // ALU lane reports
  input  logic [NUM_ALU-1:0]         alu_valid_i,
  input  alu_op_e [NUM_ALU-1:0]      alu_op_i,
  input  logic [NUM_ALU-1:0]         alu_error_i,
  // Fault status
  output class_flags_t [NUM_ALU-1:0] fault_flags_o,
  output logic [NUM_ALU-1:0]         fault_event_o
);

  wear_cfg_if #(.NUM_ALU(NUM_ALU)) cfg_if ();

  wear_apb_regs #(.NUM_ALU(NUM_ALU)) i_wear_apb_regs (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .cfg         (cfg_if.regs)
  );

  // One lane per monitored ALU
  for (genvar g = 0; g < NUM_ALU; g++) begin : g_lane
    alu_wear_lane #(.LANE(g)) i_alu_wear_lane (
      .clock_gated (clock_gated),
      .rst_n       (rst_n),
      .valid_i     (alu_valid_i[g]),
      .op_i        (alu_op_i[g]),
      .error_i     (alu_error_i[g]),
      .cfg         (cfg_if.lane),
      .event_o     (fault_event_o[g])
    );
  end

  // Flags straight from the lanes
  assign fault_flags_o = cfg_if.fault_flags;

endmodule

// File: rtl/alu_wear_pkg.sv
//////////////////////////////
// ALU wear monitor package
// Lane and class counts, opcode and class encodings, register map
//////////////////////////////
package alu_wear_pkg;

  // Geometry
  localparam int NUM_ALU   = 4;
  localparam int NUM_CLASS = 9;
  localparam int CNT_W     = 8;
  localparam int OP_W      = 6;

  // APB bus widths
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Compact opcode set, grouped four codes per class slot
  // Codes not listed here are unknown
  typedef enum logic [OP_W-1:0] {
    OP_ADD   = 6'h00,
    OP_SRL   = 6'h01,
    OP_XOR   = 6'h04,
    OP_AND   = 6'h05,
    OP_BCLR  = 6'h08,
    OP_BSET  = 6'h09,
    OP_FF1   = 6'h0C,
    OP_CNT   = 6'h0D,
    OP_SHUF  = 6'h10,
    OP_PCKLO = 6'h11,
    OP_LTS   = 6'h14,
    OP_EQ    = 6'h15,
    OP_ABS   = 6'h18,
    OP_CLIP  = 6'h19,
    OP_MIN   = 6'h1C,
    OP_MAXU  = 6'h1D,
    OP_DIV   = 6'h20,
    OP_REMU  = 6'h21
  } alu_op_e;

  // Class value equals its bit position in the fault flags
  typedef enum logic [3:0] {
    CLS_ADD_SHIFT = 4'd0,
    CLS_LOGIC     = 4'd1,
    CLS_BIT_MAN   = 4'd2,
    CLS_BIT_CNT   = 4'd3,
    CLS_SHUFFLE   = 4'd4,
    CLS_COMPARE   = 4'd5,
    CLS_ABS_CLIP  = 4'd6,
    CLS_MIN_MAX   = 4'd7,
    CLS_DIV_REM   = 4'd8,
    CLS_NONE      = 4'd15
  } op_class_e;

  // One sticky fault bit per class
  typedef logic [NUM_CLASS-1:0] class_flags_t;

  // Register offsets
  typedef enum logic [APB_AW-1:0] {
    REG_CTRL    = 8'h00,
    REG_THRESH  = 8'h04,
    REG_LEAK    = 8'h08,
    REG_CLEAR   = 8'h0C,
    REG_STATUS0 = 8'h10,
    REG_STATUS1 = 8'h14,
    REG_STATUS2 = 8'h18,
    REG_STATUS3 = 8'h1C
  } apb_addr_e;

  // Reset defaults
  localparam logic [CNT_W-1:0] THRESH_RESET = CNT_W'(104);
  localparam logic [CNT_W-1:0] LEAK_RESET   = CNT_W'(2);

endpackage

// File: rtl/wear_apb_regs.sv
//////////////////////////////
// Wear monitor APB registers
// Threshold, leak, lane enables and clear, fault status read back
//////////////////////////////
module wear_apb_regs import alu_wear_pkg::*; #(
  parameter int NUM_ALU = alu_wear_pkg::NUM_ALU
) (
  input  logic              clock_gated,
  input  logic              rst_n,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  wear_cfg_if.regs          cfg
);

  apb_addr_e          reg_addr;
  logic               access;
  logic               addr_hit;
  logic               status_hit;
  logic               wr_en;
  logic [1:0]         stat_idx;
  logic [NUM_ALU-1:0] lane_en_q;
  logic [NUM_ALU-1:0] clear_q;
  logic [CNT_W-1:0]   thresh_q;
  logic [CNT_W-1:0]   leak_q;

  assign reg_addr = apb_addr_e'(paddr_i);
  // Access phase
  assign access   = psel_i & penable_i;
  // Status word index
  assign stat_idx = paddr_i[3:2];

  //////////////////////////////
  // Address decode
  //////////////////////////////
  always_comb begin
    addr_hit   = 1'b1;
    status_hit = 1'b0;
    case (reg_addr)
      REG_CTRL, REG_THRESH, REG_LEAK, REG_CLEAR: begin
        status_hit = 1'b0;
      end
      REG_STATUS0, REG_STATUS1, REG_STATUS2, REG_STATUS3: begin
        status_hit = 1'b1;
      end
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  // Unmapped offset or write to read only status
  assign pslverr_o = access & (~addr_hit | (pwrite_i & status_hit));
  assign wr_en     = access & pwrite_i & addr_hit & ~status_hit;
  // No wait states
  assign pready_o  = 1'b1;

  //////////////////////////////
  // Writable registers
  //////////////////////////////
  always_ff @(posedge clock_gated) begin
    if (!rst_n) begin
      lane_en_q <= '1;
      thresh_q  <= THRESH_RESET;
      leak_q    <= LEAK_RESET;
      clear_q   <= '0;
    end else begin
      // Clear is a one cycle pulse
      clear_q <= '0;
      if (wr_en) begin
        case (reg_addr)
          REG_CTRL:   lane_en_q <= pwdata_i[NUM_ALU-1:0];
          REG_THRESH: thresh_q  <= pwdata_i[CNT_W-1:0];
          REG_LEAK:   leak_q    <= pwdata_i[CNT_W-1:0];
          REG_CLEAR:  clear_q   <= pwdata_i[NUM_ALU-1:0];
          default:    clear_q   <= '0;
        endcase
      end
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb begin
    prdata_o = '0;
    case (reg_addr)
      REG_CTRL:   prdata_o = APB_DW'(lane_en_q);
      REG_THRESH: prdata_o = APB_DW'(thresh_q);
      REG_LEAK:   prdata_o = APB_DW'(leak_q);
      // Clear reads back as zero
      REG_CLEAR:  prdata_o = '0;
      REG_STATUS0, REG_STATUS1, REG_STATUS2, REG_STATUS3: begin
        if (int'(stat_idx) < NUM_ALU) begin
          prdata_o = APB_DW'(cfg.fault_flags[stat_idx]);
        end
      end
      default:    prdata_o = '0;
    endcase
  end

  // Out to the lanes
  assign cfg.lane_en    = lane_en_q;
  assign cfg.lane_clear = clear_q;
  assign cfg.threshold  = thresh_q;
  assign cfg.leak       = leak_q;

endmodule

// File: rtl/wear_cfg_if.sv
//////////////////////////////
// Wear monitor config bundle
// Settings out to the lanes, fault flags back to the registers
//////////////////////////////
interface wear_cfg_if import alu_wear_pkg::*; #(
  parameter int NUM_ALU = alu_wear_pkg::NUM_ALU
);

  // Counter value that marks a class faulty
  logic [CNT_W-1:0]           threshold;
  // Amount removed by a clean op
  logic [CNT_W-1:0]           leak;
  logic [NUM_ALU-1:0]         lane_en;
  // Single cycle pulse per lane
  logic [NUM_ALU-1:0]         lane_clear;
  // Each lane drives its own slice
  class_flags_t [NUM_ALU-1:0] fault_flags;

  // Register block side
  modport regs (
    output threshold, leak, lane_en, lane_clear,
    input  fault_flags
  );

  // Lane side
  modport lane (
    input  threshold, leak, lane_en, lane_clear,
    output fault_flags
  );

endinterface

// File: run.sh
#!/bin/sh
# Build the ALU wear monitor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f src.f \
  --top-module tb_alu_wear_monitor \
  -Mdir obj_dir

# Run status is ignored here, the output decides
out=$(./obj_dir/Vtb_alu_wear_monitor 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

// File: sim/alu_wear_monitor_sva.sv
//////////////////////////////
// Wear monitor assertions
// APB response and fault event rules
//////////////////////////////
module alu_wear_monitor_sva import alu_wear_pkg::*; #(
  parameter int NUM_ALU = alu_wear_pkg::NUM_ALU
) (
  input logic                       clock_gated,
  input logic                       rst_n,
  input logic [APB_AW-1:0]          paddr_i,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic                       pwrite_i,
  input logic [APB_DW-1:0]          pwdata_i,
  input logic                       pready_i,
  input class_flags_t [NUM_ALU-1:0] fault_flags_i,
  input logic [NUM_ALU-1:0]         fault_event_i
);

  logic clear_wr;

  // Clear register written in the access phase
  assign clear_wr = psel_i & penable_i & pwrite_i & (paddr_i == REG_CLEAR);

  // Zero wait states
  a_pready: assert property (@(posedge clock_gated) pready_i)
    else $error("pready dropped low");

  for (genvar g = 0; g < NUM_ALU; g++) begin : g_lane
    // Event is a single cycle pulse
    a_event: assert property (@(posedge clock_gated) disable iff (!rst_n)
      fault_event_i[g] |=> !fault_event_i[g])
      else $error("fault event high for two cycles on lane %0d", g);

    // Clear pulse sits one cycle behind the write, flags drop one cycle later
    a_sticky: assert property (@(posedge clock_gated) disable iff (!rst_n)
      |($past(fault_flags_i[g]) & ~fault_flags_i[g]) |-> $past(clear_wr && pwdata_i[g], 2))
      else $error("fault flag fell without a clear on lane %0d", g);
  end

endmodule

bind alu_wear_monitor alu_wear_monitor_sva #(.NUM_ALU(NUM_ALU)) i_alu_wear_monitor_sva (
  .clock_gated   (clock_gated),
  .rst_n         (rst_n),
  .paddr_i       (paddr_i),
  .psel_i        (psel_i),
  .penable_i     (penable_i),
  .pwrite_i      (pwrite_i),
  .pwdata_i      (pwdata_i),
  .pready_i      (pready_o),
  .fault_flags_i (fault_flags_o),
  .fault_event_i (fault_event_o)
);

// File: sim/tb_alu_wear_monitor.sv
//////////////////////////////
// ALU wear monitor testbench
// Table driven lane traffic, APB config and a lane reference model
//////////////////////////////
module tb_alu_wear_monitor import alu_wear_pkg::*; ();

  localparam int APB_OPS = 25;
  localparam int FILL_CYCLES = 6;

  typedef struct {
    int              phase;
    string           name;
    int              lane;
    logic [OP_W-1:0] op;
    logic            valid;
    logic            err;
    int              reps;
  } row_t;

  logic                       clock_gated;
  logic                       rst_n;
  logic [APB_AW-1:0]          paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [APB_DW-1:0]          pwdata;
  logic [APB_DW-1:0]          prdata;
  logic                       pready;
  logic                       pslverr;
  logic [NUM_ALU-1:0]         alu_valid;
  alu_op_e [NUM_ALU-1:0]      alu_op;
  logic [NUM_ALU-1:0]         alu_error;
  class_flags_t [NUM_ALU-1:0] fault_flags;
  logic [NUM_ALU-1:0]         fault_event;

  row_t   rows[$];
  integer seed;
  int     err_cnt;
  int     cycle_cnt;
  int     cycle_limit;
  int     total_reps;

  // Reference model state
  int                 m_cnt [NUM_ALU][NUM_CLASS];
  class_flags_t       m_flags [NUM_ALU];
  logic [NUM_ALU-1:0] m_event;
  logic [NUM_ALU-1:0] m_en;
  logic [NUM_ALU-1:0] m_clear;
  int                 m_thresh;
  int                 m_leak;

  // Opcodes that only leak when used clean
  alu_op_e known_ops [18] = '{OP_ADD, OP_SRL, OP_XOR, OP_AND, OP_BCLR, OP_BSET,
                              OP_FF1, OP_CNT, OP_SHUF, OP_PCKLO, OP_LTS, OP_EQ,
                              OP_ABS, OP_CLIP, OP_MIN, OP_MAXU, OP_DIV, OP_REMU};

  alu_wear_monitor #(.NUM_ALU(NUM_ALU)) i_alu_wear_monitor (
    .clock_gated   (clock_gated),
    .rst_n         (rst_n),
    .paddr_i       (paddr),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .alu_valid_i   (alu_valid),
    .alu_op_i      (alu_op),
    .alu_error_i   (alu_error),
    .fault_flags_o (fault_flags),
    .fault_event_o (fault_event)
  );

  initial begin
    clock_gated = 1'b0;
    forever #20 clock_gated = ~clock_gated;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Class index of an opcode, -1 when unknown
  function automatic int class_of(logic [OP_W-1:0] op);
    case (op)
      OP_ADD, OP_SRL:    return 0;
      OP_XOR, OP_AND:    return 1;
      OP_BCLR, OP_BSET:  return 2;
      OP_FF1, OP_CNT:    return 3;
      OP_SHUF, OP_PCKLO: return 4;
      OP_LTS, OP_EQ:     return 5;
      OP_ABS, OP_CLIP:   return 6;
      OP_MIN, OP_MAXU:   return 7;
      OP_DIV, OP_REMU:   return 8;
      default:           return -1;
    endcase
  endfunction

  // One clock edge of every lane
  function automatic void model_update();
    int cls;
    int nxt;
    m_event = '0;
    for (int l = 0; l < NUM_ALU; l++) begin
      cls = class_of(alu_op[l]);
      if (m_clear[l]) begin
        for (int c = 0; c < NUM_CLASS; c++) m_cnt[l][c] = 0;
        m_flags[l] = '0;
      end else if (m_en[l] && alu_valid[l]) begin
        if (cls < 0) begin
          // Unknown op drops all progress
          for (int c = 0; c < NUM_CLASS; c++) m_cnt[l][c] = 0;
        end else if (!m_flags[l][cls]) begin
          if (alu_error[l]) begin
            nxt = (m_cnt[l][cls] < 255) ? m_cnt[l][cls] + 1 : 255;
            if (nxt >= m_thresh) begin
              m_flags[l][cls] = 1'b1;
              m_event[l]      = 1'b1;
              m_cnt[l][cls]   = 0;
            end else begin
              m_cnt[l][cls] = nxt;
            end
          end else begin
            m_cnt[l][cls] = (m_cnt[l][cls] > m_leak) ? m_cnt[l][cls] - m_leak : 0;
          end
        end
      end
    end
    m_clear = '0;
  endfunction

  task automatic compare_outputs(string name);
    for (int l = 0; l < NUM_ALU; l++) begin
      check($sformatf("%s flags lane %0d", name, l), 32'(m_flags[l]), 32'(fault_flags[l]));
    end
    check({name, " events"}, 32'(m_event), 32'(fault_event));
  endtask

  // Advance one cycle, then compare against the model
  task automatic clock_step(string name);
    @(posedge clock_gated);
    #2;
    model_update();
    compare_outputs(name);
  endtask

  task automatic drive_idle();
    alu_valid = '0;
    alu_error = '0;
    for (int l = 0; l < NUM_ALU; l++) alu_op[l] = OP_ADD;
  endtask

  //////////////////////////////
  // APB driver
  //////////////////////////////
  task automatic apb_write(string name, logic [APB_AW-1:0] addr, logic [31:0] data,
                           logic exp_err);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    // No error response in the setup phase
    @(negedge clock_gated);
    check({name, " setup pslverr"}, 32'h0, 32'(pslverr));
    clock_step(name);
    penable = 1'b1;
    @(negedge clock_gated);
    check({name, " pready"}, 32'h1, 32'(pready));
    check({name, " pslverr"}, 32'(exp_err), 32'(pslverr));
    clock_step(name);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    // Register changes reach the lanes from the next edge
    if (!exp_err) begin
      case (addr)
        REG_CTRL:   m_en     = data[NUM_ALU-1:0];
        REG_THRESH: m_thresh = int'(data[CNT_W-1:0]);
        REG_LEAK:   m_leak   = int'(data[CNT_W-1:0]);
        REG_CLEAR:  m_clear  = data[NUM_ALU-1:0];
        default:    m_clear  = '0;
      endcase
    end
  endtask

  task automatic apb_read(string name, logic [APB_AW-1:0] addr, logic [31:0] exp_data,
                          logic exp_err);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    // No error response in the setup phase
    @(negedge clock_gated);
    check({name, " setup pslverr"}, 32'h0, 32'(pslverr));
    clock_step(name);
    penable = 1'b1;
    @(negedge clock_gated);
    check({name, " pready"}, 32'h1, 32'(pready));
    check({name, " pslverr"}, 32'(exp_err), 32'(pslverr));
    if (!exp_err) check({name, " prdata"}, exp_data, prdata);
    clock_step(name);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  function automatic void add_row(int phase, string name, int lane, logic [OP_W-1:0] op,
                                  logic valid, logic err, int reps);
    row_t r;
    r.phase = phase;
    r.name  = name;
    r.lane  = lane;
    r.op    = op;
    r.valid = valid;
    r.err   = err;
    r.reps  = reps;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    add_row(0, "thresh_xor", 1, OP_XOR, 1'b1, 1'b1, 5);
    add_row(0, "thresh_idle", 1, OP_XOR, 1'b0, 1'b0, 2);
    // Errors on a flagged class never fire again
    add_row(0, "flagged_and", 1, OP_AND, 1'b1, 1'b1, 5);
    add_row(1, "leak_err_a", 0, OP_ADD, 1'b1, 1'b1, 3);
    add_row(1, "leak_clean_a", 0, OP_ADD, 1'b1, 1'b0, 1);
    add_row(1, "leak_err_b", 0, OP_ADD, 1'b1, 1'b1, 3);
    add_row(1, "leak_clean_b", 0, OP_SRL, 1'b1, 1'b0, 2);
    add_row(1, "leak_err_c", 0, OP_ADD, 1'b1, 1'b1, 4);
    add_row(1, "unknown_op", 0, 6'h3F, 1'b1, 1'b1, 1);
    add_row(1, "leak_err_d", 0, OP_SRL, 1'b1, 1'b1, 4);
    add_row(2, "leak_flag", 0, OP_SRL, 1'b1, 1'b1, 6);
    add_row(3, "iso_min", 2, OP_MIN, 1'b1, 1'b1, 5);
    add_row(3, "iso_abs", 2, OP_ABS, 1'b1, 1'b1, 4);
    add_row(4, "off_div", 3, OP_DIV, 1'b1, 1'b1, 8);
    add_row(4, "off_eq", 3, OP_EQ, 1'b1, 1'b1, 8);
    // Progress on lane 1 that the clear must wipe
    add_row(4, "pre_clear_bset", 1, OP_BSET, 1'b1, 1'b1, 3);
    add_row(5, "post_clear_bset", 1, OP_BSET, 1'b1, 1'b1, 4);
    // Lane 2 keeps its count through the lane 1 clear
    add_row(5, "keep_abs", 2, OP_ABS, 1'b1, 1'b1, 1);
  endfunction

  task automatic run_phase(int phase);
    foreach (rows[i]) begin
      if (rows[i].phase == phase) begin
        repeat (rows[i].reps) begin
          drive_idle();
          alu_valid[rows[i].lane] = rows[i].valid;
          alu_op[rows[i].lane]    = alu_op_e'(rows[i].op);
          alu_error[rows[i].lane] = rows[i].err;
          clock_step(rows[i].name);
        end
      end
    end
    drive_idle();
  endtask

  // Clean random ops on every lane
  task automatic fill_random(int n);
    logic [31:0] rnd;
    repeat (n) begin
      for (int l = 0; l < NUM_ALU; l++) begin
        rnd          = $random(seed);
        alu_valid[l] = rnd[0];
        alu_op[l]    = known_ops[rnd[15:8] % 18];
        alu_error[l] = 1'b0;
      end
      clock_step("fill");
    end
    drive_idle();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    seed        = 32'h111e;
    err_cnt     = 0;
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    drive_idle();
    build_table();
    total_reps = 0;
    foreach (rows[i]) total_reps += rows[i].reps;
    cycle_limit = 2 * (total_reps + 2 * APB_OPS + FILL_CYCLES + 4);
    // Model matches the reset state
    for (int l = 0; l < NUM_ALU; l++) begin
      for (int c = 0; c < NUM_CLASS; c++) m_cnt[l][c] = 0;
      m_flags[l] = '0;
    end
    m_event  = '0;
    m_clear  = '0;
    m_en     = '1;
    m_thresh = int'(THRESH_RESET);
    m_leak   = int'(LEAK_RESET);
    repeat (2) @(posedge clock_gated);
    #2;
    rst_n = 1'b1;

    // Reset values
    compare_outputs("reset");
    apb_read("rd_ctrl", REG_CTRL, 32'hF, 1'b0);
    apb_read("rd_thresh", REG_THRESH, 32'd104, 1'b0);
    apb_read("rd_leak", REG_LEAK, 32'd2, 1'b0);
    apb_read("rd_stat0", REG_STATUS0, 32'h0, 1'b0);
    apb_read("rd_stat1", REG_STATUS1, 32'h0, 1'b0);
    apb_read("rd_stat2", REG_STATUS2, 32'h0, 1'b0);
    apb_read("rd_stat3", REG_STATUS3, 32'h0, 1'b0);

    // Threshold of five
    apb_write("wr_thresh", REG_THRESH, 32'd5, 1'b0);
    run_phase(0);
    apb_read("thresh_stat1", REG_STATUS1, 32'h2, 1'b0);

    // Leak and unknown op
    run_phase(1);
    fill_random(FILL_CYCLES);
    run_phase(2);
    apb_read("leak_stat0", REG_STATUS0, 32'(m_flags[0]), 1'b0);

    // Class isolation and lane enable
    run_phase(3);
    apb_write("lane3_off", REG_CTRL, 32'h7, 1'b0);
    run_phase(4);
    apb_read("off_stat3", REG_STATUS3, 32'h0, 1'b0);
    apb_write("lane3_on", REG_CTRL, 32'hF, 1'b0);
    apb_read("on_ctrl", REG_CTRL, 32'hF, 1'b0);

    // Clear lane 1 only
    apb_write("clear_lane1", REG_CLEAR, 32'h2, 1'b0);
    apb_read("clr_stat1", REG_STATUS1, 32'h0, 1'b0);
    apb_read("clr_stat0", REG_STATUS0, 32'(m_flags[0]), 1'b0);
    apb_read("clr_stat2", REG_STATUS2, 32'h80, 1'b0);

    // Bad accesses leave state alone
    apb_read("rd_unmapped", 8'h20, 32'h0, 1'b1);
    apb_write("wr_unmapped", 8'h20, 32'h0, 1'b1);
    apb_write("wr_status", REG_STATUS2, 32'h0, 1'b1);
    apb_read("keep_stat2", REG_STATUS2, 32'h80, 1'b0);
    apb_read("keep_thresh", REG_THRESH, 32'd5, 1'b0);
    apb_read("keep_ctrl", REG_CTRL, 32'hF, 1'b0);
    run_phase(5);
    apb_read("final_stat1", REG_STATUS1, 32'h0, 1'b0);

    if (err_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "mismatches seen");
    end
  end

  // Watchdog on the cycle count
  initial begin
    @(posedge clock_gated);
    cycle_cnt = 1;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clock_gated);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with the test still running", cycle_cnt);
    $display("*** FAILED ***");
    $fatal(1, "simulation timeout");
  end

endmodule

// File: src.f
rtl/alu_wear_pkg.sv
rtl/wear_cfg_if.sv
rtl/alu_op_classifier.sv
rtl/alu_wear_lane.sv
rtl/wear_apb_regs.sv
rtl/alu_wear_monitor.sv
sim/alu_wear_monitor_sva.sv
sim/tb_alu_wear_monitor.sv
